// File: array_ctrl_if.sv
`timescale 1ns/100ps
`default_nettype none

interface array_ctrl_if;

    logic [1:0] data_we;    // one bit per way
    logic       refill;     // memory word, full strobe
    logic [1:0] tag_we;
    logic [1:0] inv_way;
    logic [1:0] init_way;
    logic [1:0] use_way;    // lru update

    logic [1:0] hit;
    logic       victim;

    modport ctrl (
        output data_we, refill, tag_we, inv_way, init_way, use_way,
        input  hit, victim
    );

    modport array (
        input  data_we, refill, tag_we, inv_way, init_way, use_way,
        output hit, victim
    );

endinterface

`default_nettype wire

// File: dcache_data.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_data (
    input  logic        clk,
    input  logic [31:0] lookup_addr,
    input  logic        lookup_en,
    input  logic [31:0] mem_rdata,
    dcache_req_if.consumer req,
    array_ctrl_if.array    ctl,
    output logic [31:0] rdata_way0,
    output logic [31:0] rdata_way1
);

    logic [31:0]                        data_mem [0:1][0:dcache_pkg::SETS-1];
    logic [dcache_pkg::INDEX_WIDTH-1:0] rd_idx;
    logic [dcache_pkg::INDEX_WIDTH-1:0] wr_idx;
    logic [31:0]                        wr_data;
    logic [3:0]                         wr_strb;

    assign wr_idx  = req.addr[dcache_pkg::OFFSET_WIDTH +: dcache_pkg::INDEX_WIDTH];
    assign wr_data = ctl.refill ? mem_rdata : req.wdata;
    assign wr_strb = ctl.refill ? 4'hf : req.wstrb;

    always_ff @(posedge clk) begin
        if (lookup_en) begin
            rd_idx <= lookup_addr[dcache_pkg::OFFSET_WIDTH +: dcache_pkg::INDEX_WIDTH];
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            for (int b = 0; b < 4; b++) begin
                if (ctl.data_we[w] && wr_strb[b]) begin
                    data_mem[w][wr_idx][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
    end

    assign rdata_way0 = data_mem[0][rd_idx];
    assign rdata_way1 = data_mem[1][rd_idx];

endmodule

`default_nettype wire

// File: dcache_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_fsm (
    input  logic        clk,
    input  logic        rstn,
    input  logic        valid,
    input  logic        op_valid,
    input  logic        flush,
    output logic        ready,
    output logic        op_done,
    output logic        rdata_valid,
    output logic [1:0]  rdata_sel,     // [1] memory, [0] way
    output logic        mem_req,
    output logic        mem_wr,
    input  logic        mem_addr_ok,
    input  logic        mem_data_ok,
    output logic [31:0] hit_count,
    output logic [31:0] miss_count,
    dcache_req_if.consumer req,
    array_ctrl_if.ctrl     ctl
);

    dcache_pkg::fsm_state_t state_q;
    dcache_pkg::fsm_state_t state_d;
    dcache_pkg::fsm_state_t accept_state;
    logic [1:0] hit_way;
    logic [1:0] victim_way;
    logic [1:0] addr_way;
    logic       cached_hit;
    logic       hit_inc;
    logic       miss_inc;

    // at most one way should hit, way 0 wins
    assign hit_way    = ctl.hit[0] ? 2'b01 : (ctl.hit[1] ? 2'b10 : 2'b00);
    assign victim_way = ctl.victim ? 2'b10 : 2'b01;
    assign addr_way   = req.addr[0] ? 2'b10 : 2'b01;
    assign cached_hit = (|ctl.hit) && !req.uncached;

    // where to go when ready meets a request
    assign accept_state = op_valid ? dcache_pkg::OPERATION :
                          (valid ? dcache_pkg::LOOKUP : dcache_pkg::IDLE);

    assign op_done = (state_q == dcache_pkg::OPERATION);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= dcache_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d      = state_q;
        ready        = 1'b0;
        rdata_valid  = 1'b0;
        rdata_sel    = 2'b00;
        mem_req      = 1'b0;
        mem_wr       = 1'b0;
        hit_inc      = 1'b0;
        miss_inc     = 1'b0;
        ctl.data_we  = 2'b00;
        ctl.refill   = 1'b0;
        ctl.tag_we   = 2'b00;
        ctl.inv_way  = 2'b00;
        ctl.init_way = 2'b00;
        ctl.use_way  = 2'b00;
        case (state_q)
            dcache_pkg::IDLE: begin
                ready   = 1'b1;
                state_d = accept_state;
            end
            dcache_pkg::LOOKUP: begin
                if (flush) begin
                    state_d = dcache_pkg::FLUSH;    // drop the access
                end else begin
                    hit_inc  = cached_hit;
                    miss_inc = !cached_hit;
                    if (req.uncached) ctl.inv_way = hit_way;
                    if (req.is_write) begin
                        mem_req = 1'b1;
                        mem_wr  = 1'b1;
                        if (cached_hit) begin
                            ctl.data_we = hit_way;
                            ctl.use_way = hit_way;
                        end
                        if (mem_addr_ok) begin
                            ready   = 1'b1;
                            state_d = accept_state;
                        end else begin
                            state_d = dcache_pkg::WRITE_WAIT;
                        end
                    end else if (cached_hit) begin
                        rdata_valid = 1'b1;
                        rdata_sel   = {1'b0, hit_way[1]};
                        ctl.use_way = hit_way;
                        ready       = 1'b1;
                        state_d     = accept_state;
                    end else begin
                        mem_req = 1'b1;
                        state_d = mem_data_ok ? dcache_pkg::REFILL : dcache_pkg::MISS_WAIT;
                    end
                end
            end
            dcache_pkg::MISS_WAIT: begin
                mem_req = 1'b1;
                if (mem_data_ok) state_d = dcache_pkg::REFILL;
            end
            dcache_pkg::REFILL: begin
                rdata_valid = 1'b1;
                rdata_sel   = 2'b10;
                ready       = 1'b1;
                if (!req.uncached) begin
                    ctl.refill  = 1'b1;
                    ctl.data_we = victim_way;
                    ctl.tag_we  = victim_way;
                    ctl.use_way = victim_way;
                end
                state_d = accept_state;
            end
            dcache_pkg::WRITE_WAIT: begin
                mem_req = 1'b1;
                mem_wr  = 1'b1;
                if (mem_addr_ok) begin
                    ready   = 1'b1;
                    state_d = accept_state;
                end
            end
            dcache_pkg::OPERATION: begin
                ready = !flush;
                if (!flush && req.is_op) begin
                    case (req.op)
                        dcache_pkg::OP_INDEX_INIT: ctl.init_way = addr_way;
                        dcache_pkg::OP_INDEX_INV:  ctl.inv_way  = addr_way;
                        dcache_pkg::OP_HIT_INV:    ctl.inv_way  = hit_way;
                        default: ;
                    endcase
                end
                state_d = flush ? dcache_pkg::FLUSH : accept_state;
            end
            dcache_pkg::FLUSH: begin
                ready   = !flush;   // hold off until flush drops
                state_d = flush ? dcache_pkg::FLUSH : accept_state;
            end
            default: state_d = dcache_pkg::IDLE;
        endcase
    end

    ////////////////////////////////////////
    // hit / miss counters
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstn) begin
            hit_count  <= '0;
            miss_count <= '0;
        end else begin
            if (hit_inc) hit_count <= hit_count + 32'd1;
            if (miss_inc) miss_count <= miss_count + 32'd1;
        end
    end

endmodule

`default_nettype wire

// File: dcache_lru.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_lru (
    input  logic clk,
    input  logic rstn,
    dcache_req_if.consumer req,
    array_ctrl_if.array    ctl
);

    logic [dcache_pkg::SETS-1:0]        lru_q;  // 1 = way 1 is least recent
    logic [dcache_pkg::INDEX_WIDTH-1:0] idx;

    assign idx = req.addr[dcache_pkg::OFFSET_WIDTH +: dcache_pkg::INDEX_WIDTH];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lru_q <= '0;
        end else if (ctl.use_way[0]) begin
            lru_q[idx] <= 1'b1;
        end else if (ctl.use_way[1]) begin
            lru_q[idx] <= 1'b0;
        end
    end

    assign ctl.victim = lru_q[idx];

endmodule

`default_nettype wire

// File: dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    ////////////////////////////////////////
    // cache geometry
    ////////////////////////////////////////
    localparam int INDEX_WIDTH  = 4;
    localparam int OFFSET_WIDTH = 2;
    localparam int TAG_WIDTH    = 32 - INDEX_WIDTH - OFFSET_WIDTH;
    localparam int SETS         = 1 << INDEX_WIDTH;

    ////////////////////////////////////////
    // control encodings
    ////////////////////////////////////////
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,      // tag compare of the buffered request
        MISS_WAIT,   // read outstanding on memory
        REFILL,
        WRITE_WAIT,
        OPERATION,
        FLUSH
    } fsm_state_t;

    // maintenance ops
    typedef enum logic [1:0] {
        OP_INDEX_INIT,
        OP_INDEX_INV,
        OP_HIT_INV
    } cache_op_t;

endpackage

`default_nettype wire

// File: dcache_req_buf.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_req_buf (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  valid,
    input  logic                  op_valid,
    input  logic                  accept,
    input  logic [31:0]           addr,
    input  logic [31:0]           wdata,
    input  logic [3:0]            wstrb,
    input  logic                  is_write,
    input  logic                  uncached,
    input  dcache_pkg::cache_op_t op,
    dcache_req_if.producer        req
);

    logic load;

    assign load = accept && (valid || op_valid);

    // payload fields
    always_ff @(posedge clk) begin
        if (load) begin
            req.addr  <= addr;
            req.wdata <= wdata;
            req.wstrb <= wstrb;
            req.op    <= op;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            req.is_write <= 1'b0;
            req.uncached <= 1'b0;
            req.is_op    <= 1'b0;
        end else if (load) begin
            req.is_write <= is_write && !op_valid;  // op wins over access
            req.uncached <= uncached;
            req.is_op    <= op_valid;
        end
    end

endmodule

`default_nettype wire

// File: dcache_req_if.sv
`timescale 1ns/100ps
`default_nettype none

// buffered pipeline request, held stable through lookup and waits
interface dcache_req_if;

    logic [31:0]           addr;
    logic [31:0]           wdata;
    logic [3:0]            wstrb;
    logic                  is_write;
    logic                  uncached;    // strongly ordered access
    logic                  is_op;
    dcache_pkg::cache_op_t op;

    modport producer (
        output addr, wdata, wstrb, is_write, uncached, is_op, op
    );

    modport consumer (
        input addr, wdata, wstrb, is_write, uncached, is_op, op
    );

endinterface

`default_nettype wire

// File: dcache_tagv.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_tagv (
    input  logic        clk,
    input  logic        rstn,
    input  logic [31:0] lookup_addr,
    input  logic        lookup_en,
    dcache_req_if.consumer req,
    array_ctrl_if.array    ctl
);

    logic [dcache_pkg::TAG_WIDTH-1:0]   tag_mem [0:1][0:dcache_pkg::SETS-1];
    logic [dcache_pkg::SETS-1:0]        valid_q [0:1];
    logic [dcache_pkg::INDEX_WIDTH-1:0] rd_idx;
    logic [dcache_pkg::INDEX_WIDTH-1:0] wr_idx;
    logic [dcache_pkg::TAG_WIDTH-1:0]   req_tag;

    assign wr_idx  = req.addr[dcache_pkg::OFFSET_WIDTH +: dcache_pkg::INDEX_WIDTH];
    assign req_tag = req.addr[31 -: dcache_pkg::TAG_WIDTH];

    // index taken on the accepting edge
    always_ff @(posedge clk) begin
        if (lookup_en) begin
            rd_idx <= lookup_addr[dcache_pkg::OFFSET_WIDTH +: dcache_pkg::INDEX_WIDTH];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q[0] <= '0;
            valid_q[1] <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (ctl.tag_we[w]) begin
                    valid_q[w][wr_idx] <= 1'b1;
                end else if (ctl.inv_way[w] || ctl.init_way[w]) begin
                    valid_q[w][wr_idx] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (ctl.tag_we[w]) begin
                tag_mem[w][wr_idx] <= req_tag;
            end else if (ctl.init_way[w]) begin
                tag_mem[w][wr_idx] <= '0;   // index init wipes the tag too
            end
        end
    end

    ////////////////////////////////////////
    // hit compare against buffered address
    ////////////////////////////////////////
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            ctl.hit[w] = valid_q[w][rd_idx] && (tag_mem[w][rd_idx] == req_tag);
        end
    end

endmodule

`default_nettype wire

// File: dcache_top.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_top (
    input  logic                  clk,
    input  logic                  rstn,
    // pipeline side
    input  logic                  valid,
    input  logic                  op_valid,
    input  logic                  flush,
    output logic                  ready,
    output logic                  op_done,
    input  logic [31:0]           addr,
    input  logic [31:0]           wdata,
    input  logic [3:0]            wstrb,
    input  logic                  is_write,
    input  logic                  uncached,
    input  dcache_pkg::cache_op_t op,
    output logic                  rdata_valid,
    output logic [31:0]           rdata,
    // memory side
    output logic                  mem_req,
    output logic                  mem_wr,
    output logic [31:0]           mem_addr,
    output logic [31:0]           mem_wdata,
    output logic [3:0]            mem_wstrb,
    input  logic [31:0]           mem_rdata,
    input  logic                  mem_addr_ok,
    input  logic                  mem_data_ok,
    output logic [31:0]           hit_count,
    output logic [31:0]           miss_count
);

    dcache_req_if req_bus ();
    array_ctrl_if arr_bus ();

    logic [31:0] rdata_way0;
    logic [31:0] rdata_way1;
    logic [31:0] ret_data;
    logic [1:0]  rdata_sel;

    dcache_req_buf u_req_buf (
        .clk(clk), .rstn(rstn), .valid(valid), .op_valid(op_valid), .accept(ready),
        .addr(addr), .wdata(wdata), .wstrb(wstrb), .is_write(is_write),
        .uncached(uncached), .op(op), .req(req_bus.producer)
    );

    dcache_tagv u_tagv (
        .clk(clk), .rstn(rstn), .lookup_addr(addr), .lookup_en(ready),
        .req(req_bus.consumer), .ctl(arr_bus.array)
    );

    dcache_data u_data (
        .clk(clk), .lookup_addr(addr), .lookup_en(ready), .mem_rdata(ret_data),
        .req(req_bus.consumer), .ctl(arr_bus.array),
        .rdata_way0(rdata_way0), .rdata_way1(rdata_way1)
    );

    dcache_lru u_lru (
        .clk(clk), .rstn(rstn), .req(req_bus.consumer), .ctl(arr_bus.array)
    );

    dcache_fsm u_fsm (
        .clk(clk), .rstn(rstn), .valid(valid), .op_valid(op_valid), .flush(flush),
        .ready(ready), .op_done(op_done), .rdata_valid(rdata_valid),
        .rdata_sel(rdata_sel), .mem_req(mem_req), .mem_wr(mem_wr),
        .mem_addr_ok(mem_addr_ok), .mem_data_ok(mem_data_ok),
        .hit_count(hit_count), .miss_count(miss_count),
        .req(req_bus.consumer), .ctl(arr_bus.ctrl)
    );

    // read return word, used by refill and the REFILL cycle output
    always_ff @(posedge clk) begin
        if (mem_req && !mem_wr && mem_data_ok) begin
            ret_data <= mem_rdata;
        end
    end

    assign rdata = rdata_sel[1] ? ret_data : (rdata_sel[0] ? rdata_way1 : rdata_way0);

    assign mem_addr  = req_bus.addr;
    assign mem_wdata = req_bus.wdata;
    assign mem_wstrb = req_bus.wstrb;

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module tb_dcache -o sim_dcache

out=$(./obj_dir/sim_dcache 2>&1) || true
echo "$out"

if echo "$out" | grep -q "STATUS: PASS"; then
    exit 0
else
    exit 1
fi

// File: tb.f
dcache_pkg.sv
dcache_req_if.sv
array_ctrl_if.sv
dcache_req_buf.sv
dcache_tagv.sv
dcache_data.sv
dcache_lru.sv
dcache_fsm.sv
dcache_top.sv
tb_dcache.sv

// File: tb_dcache.sv
`timescale 1ns/100ps
`default_nettype none

module tb_dcache;

    localparam int TIMEOUT = 200;

    logic        clk;
    logic        rstn;
    logic        valid;
    logic        op_valid;
    logic        flush;
    logic        ready;
    logic        op_done;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        is_write;
    logic        uncached;
    logic        rdata_valid;
    logic [31:0] rdata;
    logic        mem_req;
    logic        mem_wr;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [3:0]  mem_wstrb;
    logic [31:0] mem_rdata;
    logic        mem_addr_ok;
    logic        mem_data_ok;
    logic [31:0] hit_count;
    logic [31:0] miss_count;
    dcache_pkg::cache_op_t op;

    // memory model state
    logic [31:0] mem [logic [31:0]];
    int          mem_reads;
    int          mem_writes;
    logic [3:0]  last_wstrb;

    // reference model state
    logic                             ref_valid [0:1][0:dcache_pkg::SETS-1];
    logic [dcache_pkg::TAG_WIDTH-1:0] ref_tag   [0:1][0:dcache_pkg::SETS-1];
    logic [31:0]                      ref_data  [0:1][0:dcache_pkg::SETS-1];
    logic                             ref_lru   [0:dcache_pkg::SETS-1];
    logic [31:0]                      exp_hits;
    logic [31:0]                      exp_misses;
    int                               exp_reads;
    int                               exp_writes;

    dcache_top dut_i (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] mem_word(input logic [31:0] a);
        if (mem.exists(a)) return mem[a];
        return (a * 32'h9e3779b1) ^ 32'hc805c805;   // untouched words
    endfunction

    function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] nw,
                                          input logic [3:0] strb);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) res[8*b +: 8] = nw[8*b +: 8];
        end
        return res;
    endfunction

    function automatic logic [31:0] mk(input int tg, input int idx);
        return {tg[25:0], idx[3:0], 2'b00};
    endfunction

    // hit way of the reference model, -1 for none
    function automatic int ref_hit(input logic [31:0] a);
        for (int w = 0; w < 2; w++) begin
            if (ref_valid[w][a[5:2]] && ref_tag[w][a[5:2]] == a[31:6]) return w;
        end
        return -1;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            $display("STATUS: FAIL");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic stop_on(input string what);
        $display("%s", what);
        $display("STATUS: FAIL");
        $fatal(1, "aborted");
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    ////////////////////////////////////////
    // memory model
    ////////////////////////////////////////
    initial begin
        int unsigned dly;
        void'($urandom(32'hc805));
        forever begin
            tick();
            if (mem_req) begin
                dly = $urandom % 3;
                repeat (dly) tick();
                if (mem_wr) begin
                    mem[mem_addr] = merge(mem_word(mem_addr), mem_wdata, mem_wstrb);
                    last_wstrb = mem_wstrb;
                    mem_writes++;
                    $display("mem write %h strb %h -> %h", mem_addr, mem_wstrb, mem[mem_addr]);
                    mem_addr_ok = 1'b1;
                end else begin
                    mem_rdata = mem_word(mem_addr);
                    mem_reads++;
                    mem_data_ok = 1'b1;
                end
                tick();
                mem_addr_ok = 1'b0;
                mem_data_ok = 1'b0;
            end
        end
    end

    task automatic check_counts(input string name);
        check({name, " hits"}, exp_hits, hit_count);
        check({name, " misses"}, exp_misses, miss_count);
        check({name, " mem reads"}, exp_reads, mem_reads);
        check({name, " mem writes"}, exp_writes, mem_writes);
    endtask

    task automatic wait_done(input string name);
        int n;
        n = 0;
        #1;
        while (!ready) begin
            if (n > TIMEOUT) stop_on({name, ": cache never became ready again"});
            n++;
            @(posedge clk);
            #2;
        end
    endtask

    task automatic do_access(input string name, input logic [31:0] a, input logic wr,
                             input logic [31:0] wd, input logic [3:0] ws, input logic unc);
        int          way;
        logic [3:0]  idx;
        logic [31:0] exp;
        way = ref_hit(a);
        idx = a[5:2];
        tick();
        valid = 1'b1;
        addr = a;
        is_write = wr;
        wdata = wd;
        wstrb = ws;
        uncached = unc;
        #1;
        if (!ready) stop_on({name, ": cache not ready for a new request"});
        tick();
        valid = 1'b0;
        wait_done(name);
        if (!wr) begin
            exp = (!unc && way >= 0) ? ref_data[way][idx] : mem_word(a);
            check({name, " rdata_valid"}, 1, 32'(rdata_valid));
            check({name, " rdata"}, exp, rdata);
        end
        // predict the next state of the reference model
        if (wr) exp_writes++;
        if (unc) begin
            exp_misses++;
            if (!wr) exp_reads++;
            if (way >= 0) ref_valid[way][idx] = 1'b0;
        end else if (way >= 0) begin
            exp_hits++;
            if (wr) ref_data[way][idx] = merge(ref_data[way][idx], wd, ws);
            ref_lru[idx] = (way == 0);
        end else begin
            exp_misses++;
            if (!wr) begin
                exp_reads++;
                way = ref_lru[idx] ? 1 : 0;
                ref_valid[way][idx] = 1'b1;
                ref_tag[way][idx] = a[31:6];
                ref_data[way][idx] = mem_word(a);
                ref_lru[idx] = (way == 0);
            end
        end
        tick();
        check_counts(name);
        if (wr) check({name, " strobe"}, 32'(ws), 32'(last_wstrb));
    endtask

    task automatic do_op(input string name, input dcache_pkg::cache_op_t o, input logic [31:0] a);
        int way;
        way = ref_hit(a);
        tick();
        op_valid = 1'b1;
        op = o;
        addr = a;
        tick();
        op_valid = 1'b0;
        #1;
        check({name, " op_done"}, 1, 32'(op_done));
        tick();
        #1;
        check({name, " op_done low"}, 0, 32'(op_done));
        if (o == dcache_pkg::OP_HIT_INV) begin
            if (way >= 0) ref_valid[way][a[5:2]] = 1'b0;
        end else begin
            ref_valid[a[0]][a[5:2]] = 1'b0;
        end
        check_counts(name);
    endtask

    task automatic flush_test(input string name, input logic [31:0] a);
        tick();
        valid = 1'b1;
        is_write = 1'b0;
        uncached = 1'b0;
        addr = a;
        flush = 1'b1;   // already high when lookup starts
        tick();
        valid = 1'b0;
        #1;
        check({name, " mem_req"}, 0, 32'(mem_req));
        tick();
        #1;
        check({name, " ready held"}, 0, 32'(ready));
        flush = 1'b0;
        tick();
        check_counts(name);
        do_access({name, " retry"}, a, 0, 0, 0, 0);
    endtask

    initial begin
        clk = 0;
        rstn = 0;
        valid = 0;
        op_valid = 0;
        flush = 0;
        addr = 0;
        wdata = 0;
        wstrb = 0;
        is_write = 0;
        uncached = 0;
        op = dcache_pkg::OP_INDEX_INIT;
        mem_rdata = 0;
        mem_addr_ok = 0;
        mem_data_ok = 0;
        mem_reads = 0;
        mem_writes = 0;
        last_wstrb = 0;
        exp_hits = 0;
        exp_misses = 0;
        exp_reads = 0;
        exp_writes = 0;
        for (int s = 0; s < dcache_pkg::SETS; s++) begin
            ref_valid[0][s] = 0;
            ref_valid[1][s] = 0;
            ref_lru[s] = 0;
        end
        repeat (5) @(posedge clk);
        #1 rstn = 1;
        check_counts("reset");

        do_access("miss read", mk(1, 3), 0, 0, 0, 0);
        do_access("hit read", mk(1, 3), 0, 0, 0, 0);
        do_access("write hit", mk(1, 3), 1, 32'h1234abcd, 4'b0011, 0);
        do_access("merged read", mk(1, 3), 0, 0, 0, 0);
        do_access("write miss", mk(9, 5), 1, 32'hcafef00d, 4'b1100, 0);
        do_access("read after write miss", mk(9, 5), 0, 0, 0, 0);
        do_access("lru a", mk(2, 8), 0, 0, 0, 0);
        do_access("lru b", mk(3, 8), 0, 0, 0, 0);
        do_access("lru a again", mk(2, 8), 0, 0, 0, 0);
        do_access("lru c", mk(4, 8), 0, 0, 0, 0);
        do_access("lru b again", mk(3, 8), 0, 0, 0, 0);
        do_access("lru a last", mk(2, 8), 0, 0, 0, 0);
        do_access("cache line", mk(5, 10), 0, 0, 0, 0);
        mem[mk(5, 10)] = 32'hdeadbeef;   // cached copy is now stale
        do_access("uncached read", mk(5, 10), 0, 0, 0, 1);
        mem[mk(5, 10)] = 32'h0badf00d;
        do_access("uncached reread", mk(5, 10), 0, 0, 0, 1);
        do_access("read after uncached", mk(5, 10), 0, 0, 0, 0);
        do_access("op fill a", mk(6, 12), 0, 0, 0, 0);
        do_access("op fill b", mk(7, 12), 0, 0, 0, 0);
        do_op("index inv", dcache_pkg::OP_INDEX_INV, mk(6, 12));
        do_access("other way hit", mk(7, 12), 0, 0, 0, 0);
        do_access("inv line miss", mk(6, 12), 0, 0, 0, 0);
        do_op("hit inv", dcache_pkg::OP_HIT_INV, mk(7, 12));
        do_access("kept way hit", mk(6, 12), 0, 0, 0, 0);
        do_access("hit inv miss", mk(7, 12), 0, 0, 0, 0);
        do_op("index init", dcache_pkg::OP_INDEX_INIT, mk(0, 12) | 32'd1);
        do_access("after init a", mk(6, 12), 0, 0, 0, 0);
        do_access("after init b", mk(7, 12), 0, 0, 0, 0);
        flush_test("flush", mk(11, 14));

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire
